// File: flist.f
design/gcn_pkg.sv
design/gcn_ctrl.sv
design/adj_builder.sv
design/feat_aggregator.sv
design/transform_accum.sv
design/argmax_unit.sv
design/gcn_top.sv
verif/gcn_props.sv
verif/gcn_tb.sv

// File: Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert -Wno-fatal
TOP      ?= gcn_tb
FLIST    ?= flist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verif/gcn_tb.sv
`timescale 1ns/100ps
`default_nettype none

module gcn_tb import gcn_pkg::*; ();

    localparam int NUM_FEATS      = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_RANDOM     = 20;
    localparam int TIMEOUT_CYCLES = 25 * 60 + RESET_CYCLES;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    logic       edge_valid;
    edge_t      edge_in;
    logic       feat_valid;
    feat_beat_t feat_in;
    logic       busy;
    logic       done;
    class_vec_t y;

    // current graph and its expected result
    edge_t      edge_list[$];
    feat_t      feat_col [NUM_FEATS][NUM_NODES];
    feat_t      wgt_row  [NUM_FEATS][NUM_CLASSES];
    class_vec_t exp_y;
    int         cycles = 0;

    always #20 clk = ~clk;

    gcn_top #(
        .NUM_FEATS (NUM_FEATS)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .edge_valid (edge_valid),
        .edge_in    (edge_in),
        .feat_valid (feat_valid),
        .feat_in    (feat_in),
        .busy       (busy),
        .done       (done),
        .y          (y)
    );

    bind gcn_top gcn_props u_props (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .done  (done),
        .y     (y)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: no final result within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    ////////////////////
    // stimulus and model
    ////////////////////
    // kind 0 random, 1 equal weights, 2 no edges
    task automatic make_graph(input int kind);
        int    n_edges;
        feat_t w;
        edge_t e;
        edge_list.delete();
        n_edges = (kind == 2) ? 0 : $urandom_range(0, 9);
        for (int i = 0; i < n_edges; i++) begin
            if (i > 0 && $urandom_range(0, 4) == 0) begin
                e = edge_list[i-1];  // duplicate
            end else begin
                e.src = node_idx_t'($urandom_range(0, 7));  // 6 and 7 fall outside
                e.dst = node_idx_t'($urandom_range(0, 7));
            end
            edge_list.push_back(e);
        end
        w = feat_t'($urandom);
        for (int b = 0; b < NUM_FEATS; b++) begin
            for (int n = 0; n < NUM_NODES; n++)
                feat_col[b][n] = feat_t'($urandom);
            for (int c = 0; c < NUM_CLASSES; c++)
                wgt_row[b][c] = (kind == 1) ? w : feat_t'($urandom);
        end
    endtask

    task automatic compute_expected();
        bit adj_m [NUM_NODES][NUM_NODES];
        int score [NUM_NODES][NUM_CLASSES];
        int agg;
        int best;
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int m = 0; m < NUM_NODES; m++)
                adj_m[n][m] = 1'b0;
            for (int c = 0; c < NUM_CLASSES; c++)
                score[n][c] = 0;
        end
        foreach (edge_list[i]) begin
            if (edge_list[i].src < NUM_NODES && edge_list[i].dst < NUM_NODES) begin
                adj_m[edge_list[i].src][edge_list[i].dst] = 1'b1;
                adj_m[edge_list[i].dst][edge_list[i].src] = 1'b1;
            end
        end
        for (int b = 0; b < NUM_FEATS; b++) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                agg = 0;
                for (int m = 0; m < NUM_NODES; m++)
                    if (adj_m[n][m]) agg = agg + feat_col[b][m];
                for (int c = 0; c < NUM_CLASSES; c++)
                    score[n][c] = score[n][c] + agg * wgt_row[b][c];
            end
        end
        // lowest class wins a tie
        for (int n = 0; n < NUM_NODES; n++) begin
            best = 0;
            for (int c = 1; c < NUM_CLASSES; c++)
                if (score[n][c] > score[n][best]) best = c;
            exp_y[n] = class_idx_t'(best);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        start      = 1'b0;
        edge_valid = 1'b0;
        feat_valid = 1'b0;
    endtask

    task automatic wait_done(input int idle_gap);
        do
            @(negedge clk);
        while (!done);
        check_equal("busy at done", busy, 1);
        check_equal("y at done", y, exp_y);
        @(negedge clk);
        check_equal("done width", done, 0);
        check_equal("busy after done", busy, 0);
        check_equal("y after done", y, exp_y);
        repeat (idle_gap) begin
            @(negedge clk);
            check_equal("y held in idle", y, exp_y);
        end
    endtask

    task automatic run_graph(input int idle_gap, input bit stray, input bit gappy);
        int gap;
        if (stray) begin
            step();
            edge_valid  = 1'b1;  // idle edge, dropped
            edge_in.src = node_idx_t'($urandom_range(0, NUM_NODES - 1));
            edge_in.dst = node_idx_t'($urandom_range(0, NUM_NODES - 1));
        end
        step();
        start = 1'b1;
        foreach (edge_list[i]) begin
            step();
            edge_valid = 1'b1;
            edge_in    = edge_list[i];
        end
        if (stray) begin
            step();
            start = 1'b1;  // already busy
        end
        for (int b = 0; b < NUM_FEATS; b++) begin
            gap = gappy ? $urandom_range(0, 2) : 0;
            repeat (gap) step();
            step();
            feat_valid = 1'b1;
            for (int n = 0; n < NUM_NODES; n++)
                feat_in.feat[n] = feat_col[b][n];
            for (int c = 0; c < NUM_CLASSES; c++)
                feat_in.weight[c] = wgt_row[b][c];
            if (stray && b == 1) begin
                edge_valid  = 1'b1;  // edge during the beat stream, dropped
                edge_in.src = node_idx_t'($urandom_range(0, NUM_NODES - 1));
                edge_in.dst = node_idx_t'($urandom_range(0, NUM_NODES - 1));
            end
        end
        if (stray) begin
            step();
            feat_valid = 1'b1;  // arrives in the wait phase
            feat_in    = feat_beat_t'({$urandom, $urandom});
        end
        step();
        wait_done(idle_gap);
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        void'($urandom(49));
        rst_n      = 1'b0;
        start      = 1'b0;
        edge_valid = 1'b0;
        edge_in    = '0;
        feat_valid = 1'b0;
        feat_in    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_equal("busy after reset", busy, 0);
        check_equal("done after reset", done, 0);
        check_equal("y after reset", y, 0);

        for (int g = 0; g < NUM_RANDOM; g++) begin
            make_graph(0);
            compute_expected();
            run_graph($urandom_range(1, 3), 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
        end

        // no idle cycles between graphs
        repeat (2) begin
            make_graph(0);
            compute_expected();
            run_graph(0, 1'b0, 1'b0);
        end

        make_graph(1);  // equal weights
        compute_expected();
        run_graph(1, 1'b0, 1'b1);
        check_equal("class with equal weights", y, 0);
        make_graph(2);  // no edges, all scores zero
        compute_expected();
        run_graph(1, 1'b1, 1'b0);
        check_equal("class with no edges", y, 0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/gcn_props.sv
`timescale 1ns/100ps
`default_nettype none

module gcn_props import gcn_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       start,
    input logic       busy,
    input logic       done,
    input class_vec_t y
);

    ////////////////////
    // done pulse
    ////////////////////
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    done_while_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else $error("done seen while not busy");

    // back in idle right after done, and idle holds without a start
    idle_after_done: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
        else $error("busy still high after done");
    idle_holds: assert property (@(posedge clk) disable iff (!rst_n)
                                 (!busy && !start) |=> !busy)
        else $error("busy rose without a start");

    y_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(y))
        else $error("y has unknown bits");

endmodule

`default_nettype wire

// File: design/gcn_top.sv
`timescale 1ns/100ps
`default_nettype none

module gcn_top import gcn_pkg::*; #(
    parameter int NUM_FEATS = 8  // beats per graph, 1 to 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       edge_valid,
    input  edge_t      edge_in,
    input  logic       feat_valid,
    input  feat_beat_t feat_in,
    output logic       busy,
    output logic       done,
    output class_vec_t y
);

    logic       clear;
    logic       edge_we;
    logic       beat_valid;
    logic       beat_last;
    adj_mat_t   adj;
    logic       agg_valid;
    agg_beat_t  agg_beat;
    score_mat_t scores;
    logic       scores_ready;

    ////////////////////
    // control
    ////////////////////
    gcn_ctrl #(
        .NUM_FEATS (NUM_FEATS)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .edge_valid (edge_valid),
        .feat_valid (feat_valid),
        .done       (done),
        .clear      (clear),
        .edge_we    (edge_we),
        .beat_valid (beat_valid),
        .beat_last  (beat_last),
        .busy       (busy)
    );

    adj_builder u_adj (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .edge_we (edge_we),
        .edge_in (edge_in),
        .adj     (adj)
    );

    ////////////////////
    // datapath
    ////////////////////
    feat_aggregator u_agg (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat_last  (beat_last),
        .feat_in    (feat_in),
        .adj        (adj),
        .agg_valid  (agg_valid),
        .agg_beat   (agg_beat)
    );

    transform_accum u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .agg_valid    (agg_valid),
        .agg_beat     (agg_beat),
        .scores       (scores),
        .scores_ready (scores_ready)
    );

    argmax_unit u_argmax (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .scores       (scores),
        .scores_ready (scores_ready),
        .y            (y),
        .done         (done)  // also ends the wait phase
    );

endmodule

`default_nettype wire

// File: design/argmax_unit.sv
`timescale 1ns/100ps
`default_nettype none

module argmax_unit import gcn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  score_mat_t scores,
    input  logic       scores_ready,
    output class_vec_t y,
    output logic       done
);

    logic                         scanning;
    class_idx_t                   cls;       // class under scan
    acc_t       [NUM_NODES-1:0]   best_val;
    class_vec_t                   best_idx;
    acc_t       [NUM_NODES-1:0]   next_val;
    class_vec_t                   next_idx;
    logic                         last_cls;

    assign last_cls = (cls == class_idx_t'(NUM_CLASSES - 1));

    ////////////////////
    // compare step
    ////////////////////
    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            // class 0 seeds the best; strictly greater wins, so ties keep the lower class
            if ((cls == '0) || (scores[n][cls] > best_val[n])) begin
                next_val[n] = scores[n][cls];
                next_idx[n] = cls;
            end else begin
                next_val[n] = best_val[n];
                next_idx[n] = best_idx[n];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scanning <= 1'b0;
            cls      <= '0;
            done     <= 1'b0;
            y        <= '0;
        end else begin
            done <= 1'b0;
            if (clear) begin
                scanning <= 1'b0;
                cls      <= '0;
                y        <= '0;
            end else if (scores_ready) begin
                scanning <= 1'b1;
                cls      <= '0;
            end else if (scanning) begin
                if (last_cls) begin
                    scanning <= 1'b0;
                    cls      <= '0;
                    y        <= next_idx;  // publish with done
                    done     <= 1'b1;
                end else begin
                    cls <= cls + 1'b1;
                end
            end
        end
    end

    // running best per node
    always_ff @(posedge clk) begin
        if (scanning) begin
            best_val <= next_val;
            best_idx <= next_idx;
        end
    end

endmodule

`default_nettype wire

// File: design/transform_accum.sv
`timescale 1ns/100ps
`default_nettype none

module transform_accum import gcn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       agg_valid,
    input  agg_beat_t  agg_beat,
    output score_mat_t scores,
    output logic       scores_ready
);

    score_mat_t scores_next;

    ////////////////////
    // multiply and add
    ////////////////////
    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                // aggregate of node n times weight of class c
                scores_next[n][c] = scores[n][c]
                                  + acc_t'(agg_beat.agg[n]) * acc_t'(agg_beat.weight[c]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scores       <= '0;
            scores_ready <= 1'b0;
        end else begin
            scores_ready <= agg_valid && agg_beat.last;  // final scores out this cycle
            if (clear)
                scores <= '0;
            else if (agg_valid)
                scores <= scores_next;
        end
    end

endmodule

`default_nettype wire

// File: design/feat_aggregator.sv
`timescale 1ns/100ps
`default_nettype none

module feat_aggregator import gcn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       beat_valid,
    input  logic       beat_last,
    input  feat_beat_t feat_in,
    input  adj_mat_t   adj,
    output logic       agg_valid,
    output agg_beat_t  agg_beat
);

    agg_beat_t agg_next;

    ////////////////////
    // neighbour sums
    ////////////////////
    always_comb begin
        agg_next.weight = feat_in.weight;  // rides along to the multiplier
        agg_next.last   = beat_last;
        for (int n = 0; n < NUM_NODES; n++) begin
            agg_next.agg[n] = '0;
            for (int m = 0; m < NUM_NODES; m++) begin
                if (adj[n][m])
                    agg_next.agg[n] = agg_next.agg[n] + agg_t'(feat_in.feat[m]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            agg_valid <= 1'b0;
        end else begin
            agg_valid <= beat_valid;
        end
    end

    // payload only looked at under agg_valid
    always_ff @(posedge clk) begin
        if (beat_valid)
            agg_beat <= agg_next;
    end

endmodule

`default_nettype wire

// File: design/adj_builder.sv
`timescale 1ns/100ps
`default_nettype none

module adj_builder import gcn_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  logic     edge_we,
    input  edge_t    edge_in,
    output adj_mat_t adj
);

    logic src_ok, dst_ok;

    // indices past the last node are dropped
    assign src_ok = (edge_in.src < NUM_NODES);
    assign dst_ok = (edge_in.dst < NUM_NODES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj <= '0;
        end else if (clear) begin
            adj <= '0;  // new graph
        end else if (edge_we && src_ok && dst_ok) begin
            // both bits land on the diagonal for a self loop
            adj[edge_in.src][edge_in.dst] <= 1'b1;
            adj[edge_in.dst][edge_in.src] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/gcn_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module gcn_ctrl import gcn_pkg::*; #(
    parameter int NUM_FEATS = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic edge_valid,
    input  logic feat_valid,
    input  logic done,
    output logic clear,
    output logic edge_we,
    output logic beat_valid,
    output logic beat_last,
    output logic busy
);

    localparam int CNT_BW = $clog2(NUM_FEATS + 1);

    ctrl_state_t       state, next_state;
    logic [CNT_BW-1:0] beat_cnt;

    ////////////////////
    // strobe gating
    ////////////////////
    assign clear      = start && (state == ST_IDLE);
    assign edge_we    = edge_valid && (state == ST_LOAD);
    assign beat_valid = feat_valid && ((state == ST_LOAD) || (state == ST_AGGREGATE));
    assign beat_last  = beat_valid && (beat_cnt == CNT_BW'(NUM_FEATS - 1));
    assign busy       = (state != ST_IDLE);

    // counts accepted beats of the current graph
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (clear) begin
            beat_cnt <= '0;
        end else if (beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    ////////////////////
    // phase fsm
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start)
                    next_state = ST_LOAD;
            end
            ST_LOAD: begin
                // first beat ends the edge phase
                if (beat_last)
                    next_state = ST_WAIT;  // single-beat graph
                else if (beat_valid)
                    next_state = ST_AGGREGATE;
            end
            ST_AGGREGATE: begin
                if (beat_last)
                    next_state = ST_WAIT;
            end
            ST_WAIT: begin
                if (done)
                    next_state = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// File: design/gcn_pkg.sv
`default_nettype none

package gcn_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int NUM_NODES   = 6;
    localparam int NUM_CLASSES = 3;
    localparam int FEAT_BW     = 5;
    localparam int AGG_BW      = FEAT_BW + 3;  // room for a sum over six nodes
    localparam int ACC_BW      = 17;           // 13-bit products over up to 16 beats

    ////////////////////
    // element types
    ////////////////////
    typedef logic [2:0]         node_idx_t;
    typedef logic [1:0]         class_idx_t;
    typedef logic [FEAT_BW-1:0] feat_t;
    typedef logic [AGG_BW-1:0]  agg_t;
    typedef logic [ACC_BW-1:0]  acc_t;

    // one undirected edge in coo form
    typedef struct packed {
        node_idx_t src;
        node_idx_t dst;
    } edge_t;

    typedef struct packed {
        feat_t [NUM_NODES-1:0]   feat;    // one feature column
        feat_t [NUM_CLASSES-1:0] weight;  // one weight row
    } feat_beat_t;

    typedef struct packed {
        agg_t  [NUM_NODES-1:0]   agg;
        feat_t [NUM_CLASSES-1:0] weight;
        logic                    last;
    } agg_beat_t;

    // row n, bit m set: m is a neighbour of n
    typedef logic [NUM_NODES-1:0][NUM_NODES-1:0] adj_mat_t;
    typedef acc_t [NUM_NODES-1:0][NUM_CLASSES-1:0] score_mat_t;
    typedef class_idx_t [NUM_NODES-1:0] class_vec_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,       // taking edges, waiting for the first beat
        ST_AGGREGATE,  // taking the remaining beats
        ST_WAIT        // pipeline drain and argmax
    } ctrl_state_t;

endpackage

`default_nettype wire
